// ==== design/cam_cfg_pkg.sv ====
// Image sensor configuration types, table size and power-up timing
package cam_cfg_pkg;

    // ------------------------------------------------------------------------
    // Timing and table size
    // ------------------------------------------------------------------------

    // 20 ms settle time at a 1 MHz clock
    localparam int POWER_UP_CYCLES = 20000;
    localparam int CFG_REG_COUNT   = 40;      // Entries in the register table

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------

    typedef logic [5:0]  cfg_index_t;         // Table index
    typedef logic [15:0] sensor_addr_t;       // Sensor register address
    typedef logic [7:0]  sensor_data_t;       // Sensor register value
    typedef logic [12:0] pixel_count_t;       // Pixels per line or lines per frame
    typedef logic [14:0] power_up_count_t;    // Counts up to POWER_UP_CYCLES

    // ------------------------------------------------------------------------
    // Structures
    // ------------------------------------------------------------------------

    // One SCCB transfer handed to the external master
    typedef struct packed {
        logic         rd;     // 1 = read, 0 = write
        sensor_addr_t addr;
        sensor_data_t data;   // Don't care on reads
    } sccb_cmd_t;

    // Output window and frame timing
    typedef struct packed {
        pixel_count_t h_active;
        pixel_count_t v_active;
        pixel_count_t h_total;
        pixel_count_t v_total;
    } frame_size_t;

    // Sequencer FSM
    typedef enum logic [2:0] {
        CFG_POWER_UP,     // Wait for the sensor supplies to settle
        CFG_LOAD,         // Table stage registers the entry
        CFG_ISSUE,        // Exec strobe to the SCCB master
        CFG_WAIT_DONE,    // Master busy on the bus
        CFG_FINISHED      // Whole table sent
    } cfg_state_t;

endpackage

// ==== design/cam_cfg_sequencer.sv ====
// Configuration sequencer: power-up wait, table walk and exec/done handshake
`timescale 1ns/1ps

module cam_cfg_sequencer
    import cam_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sccb_done,    // One-cycle pulse from the SCCB master
    output cfg_index_t cfg_index,    // Entry to fetch from the table
    output logic       sccb_exec,    // One-cycle command strobe
    output logic       init_done     // Sticky completion flag
);

    cfg_state_t      state;
    cfg_state_t      state_next;
    power_up_count_t power_up_cnt;
    logic            power_up_over;
    logic            last_entry;
    logic            done_accepted;

    // ------------------------------------------------------------------------
    // Power-up wait
    // ------------------------------------------------------------------------

    assign power_up_over = (power_up_cnt == power_up_count_t'(POWER_UP_CYCLES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power_up_cnt <= '0;
        end else if (state == CFG_POWER_UP && !power_up_over) begin
            power_up_cnt <= power_up_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------

    assign last_entry    = (cfg_index == cfg_index_t'(CFG_REG_COUNT - 1));
    assign done_accepted = (state == CFG_WAIT_DONE) && sccb_done;  // Stray dones dropped

    always_comb begin
        state_next = state;
        case (state)
            CFG_POWER_UP: begin
                if (power_up_over) begin
                    state_next = CFG_LOAD;
                end
            end
            CFG_LOAD:  state_next = CFG_ISSUE;
            CFG_ISSUE: state_next = CFG_WAIT_DONE;
            CFG_WAIT_DONE: begin
                if (sccb_done) begin
                    state_next = last_entry ? CFG_FINISHED : CFG_LOAD;
                end
            end
            CFG_FINISHED: state_next = CFG_FINISHED;   // Stay here until reset
            default:      state_next = CFG_POWER_UP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CFG_POWER_UP;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------------------------------------------------
    // Index and completion
    // ------------------------------------------------------------------------

    // Next entry only once the master has finished the current one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_index <= '0;
        end else if (done_accepted && !last_entry) begin
            cfg_index <= cfg_index + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_done <= 1'b0;
        end else if (done_accepted && last_entry) begin
            init_done <= 1'b1;
        end
    end

    assign sccb_exec = (state == CFG_ISSUE);

endmodule

// ==== design/cam_reg_table.sv ====
// Sensor register table, one registered command per clock selected by index
`timescale 1ns/1ps

module cam_reg_table
    import cam_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cfg_index_t  cfg_index,
    input  frame_size_t frame_size,    // Static while the table is sent
    output sccb_cmd_t   sccb_cmd
);

    sccb_cmd_t entry;

    function automatic sccb_cmd_t wr(sensor_addr_t addr, sensor_data_t data);
        sccb_cmd_t cmd;
        cmd.rd   = 1'b0;
        cmd.addr = addr;
        cmd.data = data;
        return cmd;
    endfunction

    function automatic sccb_cmd_t rd(sensor_addr_t addr);
        sccb_cmd_t cmd;
        cmd.rd   = 1'b1;
        cmd.addr = addr;
        cmd.data = '0;
        return cmd;
    endfunction

    // ------------------------------------------------------------------------
    // Table contents
    // ------------------------------------------------------------------------

    always_comb begin
        case (cfg_index)
            // Chip ID first
            6'd0:  entry = rd(16'h300A);                 // ID high byte
            6'd1:  entry = rd(16'h300B);                 // ID low byte

            // Soft reset then wake up
            6'd2:  entry = wr(16'h3008, 8'h82);
            6'd3:  entry = wr(16'h3008, 8'h02);

            // PLL and system clocks
            6'd4:  entry = wr(16'h3103, 8'h02);          // Clock from PLL
            6'd5:  entry = wr(16'h3037, 8'h13);          // PLL root divider
            6'd6:  entry = wr(16'h3108, 8'h01);          // SCLK divider
            6'd7:  entry = wr(16'h3035, 8'h11);          // System clock divider
            6'd8:  entry = wr(16'h3036, 8'h3C);          // PLL multiplier

            // IO pad output enables
            6'd9:  entry = wr(16'h3017, 8'hFF);          // FREX, VSYNC, HREF, PCLK, D[9:6]
            6'd10: entry = wr(16'h3018, 8'hFF);          // D[5:0], GPIO1, GPIO0

            6'd11: entry = wr(16'h4300, 8'h61);          // RGB565 output

            // Sensor window, start and end corners
            6'd12: entry = wr(16'h3800, 8'h00);
            6'd13: entry = wr(16'h3801, 8'h00);
            6'd14: entry = wr(16'h3802, 8'h00);
            6'd15: entry = wr(16'h3803, 8'h04);
            6'd16: entry = wr(16'h3804, 8'h0A);
            6'd17: entry = wr(16'h3805, 8'h3F);
            6'd18: entry = wr(16'h3806, 8'h07);
            6'd19: entry = wr(16'h3807, 8'h9B);

            // Output size and total size from the frame-size input
            6'd20: entry = wr(16'h3808, {4'd0, frame_size.h_active[11:8]});
            6'd21: entry = wr(16'h3809, frame_size.h_active[7:0]);
            6'd22: entry = wr(16'h380A, {5'd0, frame_size.v_active[10:8]});
            6'd23: entry = wr(16'h380B, frame_size.v_active[7:0]);
            6'd24: entry = wr(16'h380C, {3'd0, frame_size.h_total[12:8]});
            6'd25: entry = wr(16'h380D, frame_size.h_total[7:0]);
            6'd26: entry = wr(16'h380E, {3'd0, frame_size.v_total[12:8]});
            6'd27: entry = wr(16'h380F, frame_size.v_total[7:0]);

            6'd28: entry = wr(16'h501F, 8'h01);          // ISP format mux to RGB

            // Subsampling, mirror and flip, window offsets
            6'd29: entry = wr(16'h3814, 8'h31);          // Horizontal step
            6'd30: entry = wr(16'h3815, 8'h31);          // Vertical step
            6'd31: entry = wr(16'h3820, 8'h46);
            6'd32: entry = wr(16'h3821, 8'h01);
            6'd33: entry = wr(16'h3810, 8'h00);
            6'd34: entry = wr(16'h3811, 8'h10);
            6'd35: entry = wr(16'h3812, 8'h00);
            6'd36: entry = wr(16'h3813, 8'h06);

            6'd37: entry = wr(16'h503D, 8'h00);          // Test pattern off

            // Flash strobe on, then off
            6'd38: entry = wr(16'h3019, 8'h02);
            6'd39: entry = wr(16'h3019, 8'h00);

            // Read-only ID register, harmless if ever sent
            default: entry = rd(16'h300A);
        endcase
    end

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sccb_cmd <= '0;
        end else begin
            sccb_cmd <= entry;                           // One cycle behind cfg_index
        end
    end

endmodule

// ==== design/cam_cfg_top.sv ====
// Image sensor power-up configuration: sequencer plus register table
`timescale 1ns/1ps

module cam_cfg_top
    import cam_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  frame_size_t frame_size,    // Output and total frame size

    // Command port to the external SCCB master
    input  logic        sccb_done,
    output logic        sccb_exec,
    output sccb_cmd_t   sccb_cmd,

    output logic        init_done      // High once the whole table is acknowledged
);

    cfg_index_t cfg_index;

    // Stage 1, walks the table
    cam_cfg_sequencer sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sccb_done (sccb_done),
        .cfg_index (cfg_index),
        .sccb_exec (sccb_exec),
        .init_done (init_done)
    );

    // Stage 2, registered entry lookup
    cam_reg_table reg_table_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_index  (cfg_index),
        .frame_size (frame_size),
        .sccb_cmd   (sccb_cmd)
    );

endmodule

// ==== testbench/tb_cam_cfg.sv ====
// Testbench for the camera configuration sequencer with an SCCB master model
`timescale 1ns/1ps

module tb_cam_cfg
    import cam_cfg_pkg::*;
();

    localparam int CLK_PERIOD_NS = 100;
    localparam int RUN_CYCLES    = POWER_UP_CYCLES + CFG_REG_COUNT * 24;   // One full table
    localparam int WATCHDOG_NS   = 2 * 5 * RUN_CYCLES * CLK_PERIOD_NS;
    localparam frame_size_t DEFAULT_FRAME = {13'd640, 13'd480, 13'd1896, 13'd984};

    logic        clk;
    logic        rst_n;
    frame_size_t frame_size;
    logic        model_done = 1'b0;
    logic        inject_done;           // Stray done pulses from the tests
    logic        sccb_done;
    logic        sccb_exec;
    sccb_cmd_t   sccb_cmd;
    logic        init_done;

    // What the master model saw since the last reset
    sccb_cmd_t   cmd_q[$];
    int          exec_cycles[$];
    int          done_cycles[$];
    int          cycle_count;           // Cycles since reset release
    int          init_cycle;
    int          overlap_count;         // Exec while a command was pending
    int          late_exec_count;       // Exec after init_done
    int          delay_left;
    logic        busy;
    logic [31:0] delay_rng = 32'd44;
    logic [31:0] stim_rng  = 32'd44;

    int error_count;
    int test_count;
    int failed_tests;

    assign sccb_done = model_done | inject_done;

    cam_cfg_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_size (frame_size),
        .sccb_done  (sccb_done),
        .sccb_exec  (sccb_exec),
        .sccb_cmd   (sccb_cmd),
        .init_done  (init_done)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Two bytes per count from 0x3808 up, high byte at the even address
    function automatic sensor_data_t expected_size_byte(frame_size_t fs, sensor_addr_t addr);
        int           slot;
        pixel_count_t count;
        pixel_count_t high_mask;
        slot = int'(addr - 16'h3808);
        case (slot / 2)
            0: begin
                count     = fs.h_active;
                high_mask = 13'h0F00;       // Bits 11 to 8
            end
            1: begin
                count     = fs.v_active;
                high_mask = 13'h0700;       // Bits 10 to 8
            end
            2: begin
                count     = fs.h_total;
                high_mask = 13'h1F00;
            end
            default: begin
                count     = fs.v_total;
                high_mask = 13'h1F00;
            end
        endcase
        if (slot % 2 == 0) begin
            return sensor_data_t'((count & high_mask) >> 8);
        end
        return sensor_data_t'(count & 13'h00FF);
    endfunction

    // ------------------------------------------------------------------------
    // SCCB master model answering each exec after 1 to 20 cycles
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        model_done <= 1'b0;
        if (!rst_n) begin
            cmd_q.delete();
            exec_cycles.delete();
            done_cycles.delete();
            cycle_count     = 0;
            init_cycle      = 0;
            overlap_count   = 0;
            late_exec_count = 0;
            busy            = 1'b0;
        end else begin
            cycle_count++;
            if (sccb_exec) begin
                if (busy) overlap_count++;
                if (init_cycle != 0) late_exec_count++;
                cmd_q.push_back(sccb_cmd);
                exec_cycles.push_back(cycle_count);
                delay_rng  = xorshift32(delay_rng);
                delay_left = 1 + int'(delay_rng % 32'd20);
                busy       = 1'b1;
            end else if (busy) begin
                delay_left--;
                if (delay_left == 0) begin
                    model_done <= 1'b1;
                    busy = 1'b0;
                    done_cycles.push_back(cycle_count);
                end
            end
            if (init_done && init_cycle == 0) init_cycle = cycle_count;
        end
    end

    task automatic report_fail(string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    // Returns on the falling edge where reset is released
    task automatic apply_reset(frame_size_t fs);
        @(negedge clk);
        rst_n      <= 1'b0;
        frame_size <= fs;
        repeat (8) @(negedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_for_init();
        int waited;
        waited = 0;
        while (!init_done && waited < RUN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!init_done) begin
            $display("Timeout: init_done did not rise within %0d cycles", RUN_CYCLES);
            error_count++;
        end
        repeat (40) @(negedge clk);    // Window for stray execs after completion
        @(posedge clk);                // Model records only change on negedge
    endtask

    task automatic end_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("[%0t ns] %s: passed", $time, name);
        end else begin
            $display("[%0t ns] %s: %0d errors", $time, name, error_count - errors_before);
            failed_tests++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_power_up();
        int errors_before;
        errors_before = error_count;
        apply_reset(DEFAULT_FRAME);
        assert (!sccb_exec && !init_done)
            else report_fail("sccb_exec or init_done high during reset");
        repeat (100) @(negedge clk);
        inject_done <= 1'b1;           // Stray done inside the power-up wait
        @(negedge clk);
        inject_done <= 1'b0;
        wait_for_init();
        assert (exec_cycles.size() > 0 && exec_cycles[0] == POWER_UP_CYCLES + 2)
            else report_fail($sformatf("first exec at cycle %0d, expected %0d",
                                       exec_cycles[0], POWER_UP_CYCLES + 2));
        end_test("reset_power_up", errors_before);
    endtask

    task automatic test_id_reads();
        int errors_before;
        errors_before = error_count;
        apply_reset(DEFAULT_FRAME);
        wait_for_init();
        assert (cmd_q.size() >= 2) else report_fail("fewer than two commands issued");
        assert (cmd_q[0].rd && cmd_q[0].addr == 16'h300A)
            else report_fail("command 0 is not a read of 0x300A");
        assert (cmd_q[1].rd && cmd_q[1].addr == 16'h300B)
            else report_fail("command 1 is not a read of 0x300B");
        for (int i = 2; i < cmd_q.size(); i++) begin
            assert (!cmd_q[i].rd) else report_fail($sformatf("command %0d is a read", i));
        end
        end_test("id_reads", errors_before);
    endtask

    task automatic test_frame_size();
        int          errors_before;
        int          found;
        frame_size_t fs;
        errors_before = error_count;
        stim_rng    = xorshift32(stim_rng);
        fs.h_active = stim_rng[12:0];
        fs.v_active = stim_rng[25:13];
        stim_rng    = xorshift32(stim_rng);
        fs.h_total  = stim_rng[12:0];
        fs.v_total  = stim_rng[25:13];
        // Top bits set so both kept and dropped high bits show up
        fs.h_active[12:11] = 2'b11;
        fs.v_active[12:10] = 3'b111;
        fs.h_total[12]     = 1'b1;
        fs.v_total[12]     = 1'b1;
        apply_reset(fs);
        wait_for_init();
        found = 0;
        foreach (cmd_q[i]) begin
            if (cmd_q[i].addr >= 16'h3808 && cmd_q[i].addr <= 16'h380F) begin
                found++;
                assert (cmd_q[i].data == expected_size_byte(fs, cmd_q[i].addr))
                    else report_fail($sformatf("0x%04h written with 0x%02h, expected 0x%02h",
                        cmd_q[i].addr, cmd_q[i].data, expected_size_byte(fs, cmd_q[i].addr)));
            end
        end
        assert (found == 8)
            else report_fail($sformatf("%0d frame-size writes, expected 8", found));
        end_test("frame_size", errors_before);
    endtask

    task automatic test_count_completion();
        int errors_before;
        errors_before = error_count;
        apply_reset(DEFAULT_FRAME);
        wait_for_init();
        assert (cmd_q.size() == CFG_REG_COUNT)
            else report_fail($sformatf("%0d commands, expected %0d",
                                       cmd_q.size(), CFG_REG_COUNT));
        assert (done_cycles.size() > 0 && init_cycle == done_cycles[done_cycles.size() - 1] + 1)
            else report_fail("init_done not one cycle after the last done");
        assert (late_exec_count == 0) else report_fail("sccb_exec after init_done");
        end_test("count_completion", errors_before);
    endtask

    task automatic test_back_pressure();
        int errors_before;
        errors_before = error_count;
        apply_reset(DEFAULT_FRAME);
        wait_for_init();
        assert (overlap_count == 0) else report_fail("sccb_exec while a command was pending");
        assert (done_cycles.size() == exec_cycles.size())
            else report_fail("done count differs from exec count");
        for (int i = 1; i < exec_cycles.size(); i++) begin
            assert (exec_cycles[i] == done_cycles[i - 1] + 2)
                else report_fail($sformatf("exec %0d at cycle %0d, done at %0d",
                                           i, exec_cycles[i], done_cycles[i - 1]));
        end
        end_test("back_pressure", errors_before);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        frame_size   = '0;
        inject_done  = 1'b0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        test_reset_power_up();
        test_id_reads();
        test_frame_size();
        test_count_completion();
        test_back_pressure();
        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog at twice the length of five full runs
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
design/cam_cfg_pkg.sv
design/cam_cfg_sequencer.sv
design/cam_reg_table.sv
design/cam_cfg_top.sv
testbench/tb_cam_cfg.sv

// ==== Makefile ====
# Verilator build and run for the camera configuration sequencer

TOP := tb_cam_cfg
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f src.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "No result in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
